/* stepctl.f */
+incdir+src
src/stepctl_pkg.sv
src/spi_word_rx.sv
src/cmd_regs.sv
src/move_queue.sv
src/dda_step_gen.sv
src/quad_enc.sv
src/stepctl_top.sv
tb/stepctl_tb.sv

/* tb/stepctl_tb.sv */
`timescale 1ns/1ps
`include "stepctl_params.svh"

module stepctl_tb;
  import stepctl_pkg::*;

  logic CLK;
  logic reset, sck, cs, copi, enc_a, enc_b;
  logic cipo, step, dir, motor_enable, buffer_dtr, move_done, enc_fault;

  int          errors = 0;
  int          timeouts = 0;
  int          step_count = 0;  // Running pulse totals
  int          done_count = 0;
  accum_t      model_phase = '0; // Reference accumulator carried across moves
  logic [31:0] rng_state = 32'hae21;
  logic [1:0]  enc_state = 2'b00; // Driven {a, b}

  stepctl_top dut0 (
    .CLK(CLK), .reset(reset), .sck(sck), .cs(cs), .copi(copi), .enc_a(enc_a),
    .enc_b(enc_b), .cipo(cipo), .step(step), .dir(dir), .motor_enable(motor_enable),
    .buffer_dtr(buffer_dtr), .move_done(move_done), .enc_fault(enc_fault)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK; // 4 ns period
  end

  // Pulse counters sampled mid-cycle
  always @(negedge CLK) begin
    if (step === 1'b1) step_count <= step_count + 1;
    if (move_done === 1'b1) done_count <= done_count + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // DDA reference model giving the steps of one move and advancing model_phase
  function automatic int model_move(input int dur, input accum_t inc0, input accum_t accel);
    int     t;
    int     steps;
    accum_t inc;
    accum_t sum;
    steps = 0;
    inc = inc0;
    for (t = 0; t < dur; t++) begin
      sum = model_phase + inc;
      if (sum >= `STEP_THRESHOLD) begin
        sum = sum - `STEP_THRESHOLD; // One step per tick at most
        steps++;
      end
      model_phase = sum;
      inc = inc + accel;             // Increment grows after the add
    end
    return steps;
  endfunction

  task automatic report_mismatch(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[FAIL] %s expected %0h actual %0h", test, exp, act);
    errors++;
  endtask

  // One 64-bit mode 0 frame MSB first with 5 cycles per SCK half
  task automatic spi_xfer(input word_t tx, output word_t rx);
    int i;
    rx = '0;
    @(posedge CLK);
    cs <= 1'b0;
    for (i = 63; i >= 0; i--) begin
      copi <= tx[i];                 // Set up while SCK low
      repeat (4) @(posedge CLK);
      @(negedge CLK);
      rx = {rx[62:0], cipo};         // CIPO settled since last fall
      @(posedge CLK);
      sck <= 1'b1;
      repeat (5) @(posedge CLK);
      sck <= 1'b0;
    end
    repeat (5) @(posedge CLK);
    cs <= 1'b1;
    repeat (6) @(posedge CLK);       // Gap between frames
  endtask

  task automatic send_cmd(input header_t hdr, input logic [7:0] value);
    word_t r;
    spi_xfer({hdr, 48'd0, value}, r);
  endtask

  // Four-word move whose accel frame brings back the reply
  task automatic send_move(input logic d, input word_t dur, input accum_t inc,
                           input accum_t accel, output word_t reply);
    word_t r;
    spi_xfer({`CMD_COORDINATED_STEP, 55'd0, d}, r);
    spi_xfer(dur, r);
    spi_xfer(word_t'(inc), r);
    spi_xfer(word_t'(accel), reply);
  endtask

  task automatic enc_step(input logic fwd);
    logic [1:0] nxt;
    case (enc_state)         // Forward 00 01 11 10
      2'b00:   nxt = fwd ? 2'b01 : 2'b10;
      2'b01:   nxt = fwd ? 2'b11 : 2'b00;
      2'b11:   nxt = fwd ? 2'b10 : 2'b01;
      default: nxt = fwd ? 2'b00 : 2'b11;
    endcase
    enc_state = nxt;
    @(posedge CLK);
    enc_a <= nxt[1];
    enc_b <= nxt[0];
    repeat (3) @(posedge CLK);
  endtask

  task automatic wait_moves(input int target, input int limit, input string test);
    int n;
    n = 0;
    while (done_count < target && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (done_count < target) begin
      $display("Timeout in %s: only %0d of %0d moves finished", test, done_count, target);
      timeouts++;
    end
    repeat (10) @(negedge CLK); // Catch any stray pulse
  endtask

  task automatic reset_and_version();
    word_t r;
    word_t exp_ver;
    exp_ver = (word_t'(`VERSION_MAJOR) << 16) | (word_t'(`VERSION_MINOR) << 8) |
              word_t'(`VERSION_PATCH);  // Bytes 2, 1 and 0
    @(negedge CLK);
    if (step !== 1'b0) report_mismatch("reset_version", 0, step);
    if (move_done !== 1'b0) report_mismatch("reset_version", 0, move_done);
    if (motor_enable !== 1'b0) report_mismatch("reset_version", 0, motor_enable);
    if (enc_fault !== 1'b0) report_mismatch("reset_version", 0, enc_fault);
    if (cipo !== 1'b0) report_mismatch("reset_version", 0, cipo);
    if (buffer_dtr !== 1'b1) report_mismatch("reset_version", 1, buffer_dtr);
    send_cmd(`CMD_API_VERSION, 8'd0);
    spi_xfer('0, r);                 // Reply arrives one frame late
    if (r !== exp_ver)
      report_mismatch("reset_version", exp_ver, r);
  endtask

  task automatic enable_single_move();
    int     s0, d0, exp_steps;
    word_t  r;
    accum_t half;
    half = `STEP_THRESHOLD >>> 1;
    s0 = step_count;
    d0 = done_count;
    send_cmd(`CMD_MOTOR_ENABLE, 8'd1);
    send_cmd(`CMD_CLK_DIVISOR, 8'd3);
    exp_steps = model_move(10, half, '0);
    send_move(1'b1, 64'd10, half, '0, r);
    wait_moves(d0 + 1, 1000, "single_move");
    if (motor_enable !== 1'b1) report_mismatch("single_move", 1, motor_enable);
    if (dir !== 1'b1) report_mismatch("single_move", 1, dir);
    if (step_count - s0 != exp_steps) report_mismatch("single_move", exp_steps, step_count - s0);
    if (done_count - d0 != 1) report_mismatch("single_move", 1, done_count - d0);
  endtask

  task automatic accel_carry_over();
    int          s0, d0, k, dur, exp_steps;
    logic [31:0] ri, ra;
    accum_t      inc, accel;
    word_t       r;
    s0 = step_count;
    d0 = done_count;
    exp_steps = 0;
    for (k = 0; k < 3; k++) begin
      ri = next_rand();
      ra = next_rand();
      inc = accum_t'({32'd0, ri});          // Below one step per tick
      accel = accum_t'({40'd0, ra[23:0]}) + 64'sd1; // Never zero
      dur = 16 + int'(ri[3:0]);
      exp_steps += model_move(dur, inc, accel);
      send_move(k[0], word_t'(dur), inc, accel, r);
    end
    wait_moves(d0 + 3, 5000, "accel_moves");
    if (dir !== 1'b0) report_mismatch("accel_moves", 0, dir); // Last move runs backward
    if (step_count - s0 != exp_steps) report_mismatch("accel_moves", exp_steps, step_count - s0);
    if (done_count - d0 != 3) report_mismatch("accel_moves", 3, done_count - d0);
  endtask

  task automatic fill_queue();
    int     s0, d0, k, n, exp_steps;
    accum_t quarter;
    word_t  r;
    quarter = `STEP_THRESHOLD >>> 2;
    s0 = step_count;
    d0 = done_count;
    exp_steps = 0;
    send_cmd(`CMD_MOTOR_ENABLE, 8'd0);       // Generator holds in idle
    for (k = 0; k < `MOVE_QUEUE_DEPTH; k++) begin
      exp_steps += model_move(3, quarter, '0);
      send_move(1'b0, 64'd3, quarter, '0, r);
    end
    @(negedge CLK);
    if (buffer_dtr !== 1'b0) report_mismatch("queue_full", 0, buffer_dtr);
    send_cmd(`CMD_MOTOR_ENABLE, 8'd1);
    n = 0;
    while (buffer_dtr !== 1'b1 && n < 100) begin
      @(negedge CLK);
      n++;
    end
    if (buffer_dtr !== 1'b1) begin
      $display("Timeout in queue_full: buffer_dtr stayed low after enable");
      timeouts++;
    end
    wait_moves(d0 + `MOVE_QUEUE_DEPTH, 5000, "queue_full");
    if (step_count - s0 != exp_steps) report_mismatch("queue_full", exp_steps, step_count - s0);
  endtask

  task automatic encoder_position();
    int    k, n;
    word_t r;
    for (k = 0; k < 12; k++) enc_step(1'b1);
    for (k = 0; k < 5; k++) enc_step(1'b0);
    send_move(1'b0, 64'd0, '0, '0, r);    // Empty move so only the snapshot matters
    if (r !== word_t'(accum_t'(12 - 5))) report_mismatch("encoder", 12 - 5, r);
    @(posedge CLK);
    enc_a <= ~enc_state[1];               // Both bits flip at once
    enc_b <= ~enc_state[0];
    n = 0;
    while (enc_fault !== 1'b1 && n < 20) begin
      @(negedge CLK);
      n++;
    end
    if (enc_fault !== 1'b1) begin
      $display("Timeout in encoder: enc_fault not set by double transition");
      timeouts++;
    end
  endtask

  initial begin
    reset <= 1'b1;
    sck   <= 1'b0;
    cs    <= 1'b1;
    copi  <= 1'b0;
    enc_a <= 1'b0;
    enc_b <= 1'b0;
    repeat (8) @(posedge CLK);
    reset <= 1'b0;
    repeat (2) @(posedge CLK);
    reset_and_version();
    enable_single_move();
    accel_carry_over();
    fill_queue();
    encoder_position();
    $display("Value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* src/stepctl_top.sv */
`timescale 1ns/1ps

module stepctl_top (
  input  logic CLK,
  input  logic reset,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic step,
  output logic dir,
  output logic motor_enable,
  output logic buffer_dtr,
  output logic move_done,
  output logic enc_fault
);
  import stepctl_pkg::*;

  word_t      rx_word;
  word_t      tx_word;
  logic       word_strobe;
  accum_t     enc_count;
  motor_cfg_t cfg;
  logic       push;
  move_t      push_move;
  move_t      head_move;
  logic       queue_empty;
  logic       pop;

  assign motor_enable = cfg.enable;

  spi_word_rx spi0 (
    .CLK(CLK), .reset(reset), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .tx_word(tx_word), .rx_word(rx_word), .word_strobe(word_strobe)
  );

  cmd_regs regs0 (
    .CLK(CLK), .reset(reset), .word_strobe(word_strobe), .rx_word(rx_word),
    .enc_count(enc_count), .buffer_dtr(buffer_dtr), .tx_word(tx_word),
    .cfg(cfg), .push(push), .push_move(push_move)
  );

  move_queue queue0 (
    .CLK(CLK), .reset(reset), .push(push), .push_move(push_move), .pop(pop),
    .head_move(head_move), .queue_empty(queue_empty), .buffer_dtr(buffer_dtr)
  );

  dda_step_gen dda0 (
    .CLK(CLK), .reset(reset), .cfg(cfg), .head_move(head_move),
    .queue_empty(queue_empty), .pop(pop), .step(step), .dir(dir),
    .move_done(move_done)
  );

  quad_enc enc0 (
    .CLK(CLK), .reset(reset), .a(enc_a), .b(enc_b),
    .count(enc_count), .fault(enc_fault)
  );

endmodule

/* src/quad_enc.sv */
`timescale 1ns/1ps

module quad_enc (
  input  logic                CLK,
  input  logic                reset,
  input  logic                a,
  input  logic                b,
  output stepctl_pkg::accum_t count,
  output logic                fault
);
  import stepctl_pkg::*;

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic [1:0] cur;   // {a, b} after sync
  logic [1:0] prev;

  assign cur = {a_sync[1], b_sync[1]};

  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[0], a};
    b_sync <= {b_sync[0], b};
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      prev  <= cur;                  // No count from the idle level
      count <= '0;
      fault <= 1'b0;
    end else begin
      prev <= cur;
      case ({prev, cur})
        // Forward 00 01 11 10
        4'b0001, 4'b0111, 4'b1110, 4'b1000: count <= count + 64'sd1;
        // Reverse
        4'b0010, 4'b1011, 4'b1101, 4'b0100: count <= count - 64'sd1;
        // Both bits moved, position lost
        4'b0011, 4'b1100, 4'b0110, 4'b1001: fault <= 1'b1;
        default: ;                   // No change
      endcase
    end
  end

endmodule

/* src/dda_step_gen.sv */
`timescale 1ns/1ps
`include "stepctl_params.svh"

module dda_step_gen (
  input  logic                    CLK,
  input  logic                    reset,
  input  stepctl_pkg::motor_cfg_t cfg,
  input  stepctl_pkg::move_t      head_move,
  input  logic                    queue_empty,
  output logic                    pop,
  output logic                    step,
  output logic                    dir,
  output logic                    move_done
);
  import stepctl_pkg::*;

  dda_state_t state;
  clk_div_t   div_cnt;   // Cycles to next tick
  word_t      remaining; // Ticks left in move
  accum_t     incr;
  accum_t     accel;
  accum_t     accum;     // Phase, kept across moves
  accum_t     tick_sum;
  logic       tick;

  // Take the head as soon as idle and enabled
  assign pop      = (state == DDA_IDLE) && !queue_empty && cfg.enable;
  assign tick     = (state == DDA_RUN) && cfg.enable && (div_cnt == '0);
  assign tick_sum = accum + incr;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state     <= DDA_IDLE;
      accum     <= '0;
      step      <= 1'b0;
      move_done <= 1'b0;
      dir       <= 1'b0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      case (state)
        DDA_IDLE:
          if (pop) begin
            dir <= head_move.dir;
            if (head_move.duration == '0)
              move_done <= 1'b1;     // Empty move done at load
            else
              state <= DDA_RUN;
          end
        DDA_RUN:
          if (tick) begin
            if (tick_sum >= `STEP_THRESHOLD) begin
              accum <= tick_sum - `STEP_THRESHOLD;
              step  <= 1'b1;
            end else begin
              accum <= tick_sum;
            end
            if (remaining == 64'd1) begin
              move_done <= 1'b1;     // Same cycle as the last step
              state     <= DDA_IDLE;
            end
          end
        default: state <= DDA_IDLE;
      endcase
    end
  end

  // Move parameters and tick divider
  always_ff @(posedge CLK) begin
    if (pop) begin
      remaining <= head_move.duration;
      incr      <= head_move.increment;
      accel     <= head_move.accel;
      div_cnt   <= cfg.clk_div;
    end else if (state == DDA_RUN && cfg.enable) begin
      if (tick) begin
        div_cnt   <= cfg.clk_div;    // Period clk_div+1
        remaining <= remaining - 64'd1;
        incr      <= incr + accel;   // After the add to accum
      end else begin
        div_cnt <= div_cnt - 1'b1;
      end
    end
  end

endmodule

/* src/move_queue.sv */
`timescale 1ns/1ps
`include "stepctl_params.svh"

module move_queue (
  input  logic               CLK,
  input  logic               reset,
  input  logic               push,
  input  stepctl_pkg::move_t push_move,
  input  logic               pop,
  output stepctl_pkg::move_t head_move,
  output logic               queue_empty,
  output logic               buffer_dtr
);
  import stepctl_pkg::*;

  move_t                      slots [`MOVE_QUEUE_DEPTH];
  logic [`MOVE_QUEUE_BITS:0]  wr_ptr;  // Extra bit tells full from empty
  logic [`MOVE_QUEUE_BITS:0]  rd_ptr;
  logic                       full;

  assign queue_empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[`MOVE_QUEUE_BITS] != rd_ptr[`MOVE_QUEUE_BITS]) &&
                (wr_ptr[`MOVE_QUEUE_BITS-1:0] == rd_ptr[`MOVE_QUEUE_BITS-1:0]);
  assign buffer_dtr = ~full;
  assign head_move  = slots[rd_ptr[`MOVE_QUEUE_BITS-1:0]];

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full)
        wr_ptr <= wr_ptr + 1'b1;  // Push while full dropped here
      if (pop && !queue_empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push && !full)
      slots[wr_ptr[`MOVE_QUEUE_BITS-1:0]] <= push_move;
  end

endmodule

/* src/cmd_regs.sv */
`timescale 1ns/1ps
`include "stepctl_params.svh"

module cmd_regs (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    word_strobe,
  input  stepctl_pkg::word_t      rx_word,
  input  stepctl_pkg::accum_t     enc_count,
  input  logic                    buffer_dtr,
  output stepctl_pkg::word_t      tx_word,
  output stepctl_pkg::motor_cfg_t cfg,
  output logic                    push,
  output stepctl_pkg::move_t      push_move
);
  import stepctl_pkg::*;

  msg_state_t state;
  header_t    header;
  accum_t     enc_snap;  // Position at move header

  assign header = rx_word[63:56];

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= MSG_HEADER;
      cfg     <= '{enable: 1'b0, clk_div: `CLK_DIV_RESET};
      tx_word <= '0;
      push    <= 1'b0;
    end else begin
      push <= 1'b0;
      if (word_strobe) begin
        case (state)
          MSG_HEADER: begin
            tx_word <= '0;            // Reply cleared unless set below
            case (header)
              `CMD_MOTOR_ENABLE: cfg.enable  <= rx_word[0];
              `CMD_CLK_DIVISOR:  cfg.clk_div <= rx_word[7:0];
              `CMD_API_VERSION:
                tx_word <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
              `CMD_COORDINATED_STEP: state <= MSG_DURATION;
              default: ;              // Unknown header
            endcase
          end
          MSG_DURATION:  state <= MSG_INCREMENT;
          MSG_INCREMENT: begin
            tx_word <= word_t'(enc_snap); // Goes out on the accel frame
            state   <= MSG_ACCEL;
          end
          MSG_ACCEL: begin
            push  <= buffer_dtr;      // Move lost if queue full
            state <= MSG_HEADER;
          end
          default: state <= MSG_HEADER;
        endcase
      end
    end
  end

  // Move record assembly
  always_ff @(posedge CLK) begin
    if (word_strobe) begin
      case (state)
        MSG_HEADER:
          if (header == `CMD_COORDINATED_STEP) begin
            push_move.dir <= rx_word[0];
            enc_snap      <= enc_count;
          end
        MSG_DURATION:  push_move.duration  <= rx_word;
        MSG_INCREMENT: push_move.increment <= accum_t'(rx_word);
        MSG_ACCEL:     push_move.accel     <= accum_t'(rx_word);
        default: ;
      endcase
    end
  end

endmodule

/* src/spi_word_rx.sv */
`timescale 1ns/1ps

module spi_word_rx (
  input  logic               CLK,
  input  logic               reset,
  input  logic               sck,
  input  logic               cs,
  input  logic               copi,
  output logic               cipo,
  input  stepctl_pkg::word_t tx_word,
  output stepctl_pkg::word_t rx_word,
  output logic               word_strobe
);
  import stepctl_pkg::*;

  logic [1:0] sck_sync;  // Two-flop synchronizers
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_prev;
  logic       cs_prev;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_rise;
  logic       cs_fall;
  logic [5:0] bit_cnt;   // Wraps after 64 rises
  logic       got_all;   // Last rise was rise number 64
  word_t      rx_shift;
  word_t      tx_shift;

  // Edges only count while selected
  assign sck_rise = sck_sync[1] & ~sck_prev & ~cs_sync[1];
  assign sck_fall = ~sck_sync[1] & sck_prev & ~cs_sync[1];
  assign cs_fall  = ~cs_sync[1] & cs_prev;
  assign cs_rise  = cs_sync[1] & ~cs_prev;
  assign cipo     = tx_shift[63]; // MSB first

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_sync    <= 2'b00;
      cs_sync     <= 2'b11;      // Deselected
      sck_prev    <= 1'b0;
      cs_prev     <= 1'b1;
      bit_cnt     <= '0;
      got_all     <= 1'b0;
      tx_shift    <= '0;
      word_strobe <= 1'b0;
    end else begin
      sck_sync    <= {sck_sync[0], sck};
      cs_sync     <= {cs_sync[0], cs};
      sck_prev    <= sck_sync[1];
      cs_prev     <= cs_sync[1];
      word_strobe <= 1'b0;
      if (cs_fall) begin
        // Start of frame, load reply
        bit_cnt  <= '0;
        got_all  <= 1'b0;
        tx_shift <= tx_word;
      end else if (cs_rise) begin
        word_strobe <= got_all;   // Short or long frames dropped
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 6'd1;
          got_all <= (bit_cnt == 6'd63);
        end
        if (sck_fall)
          tx_shift <= {tx_shift[62:0], 1'b0}; // Next bit out
      end
    end
  end

  // Received data path
  always_ff @(posedge CLK) begin
    copi_sync <= {copi_sync[0], copi};
    if (sck_rise && !cs_fall)
      rx_shift <= {rx_shift[62:0], copi_sync[1]};
    if (cs_rise && got_all)
      rx_word <= rx_shift;        // Held until next complete frame
  end

endmodule

/* src/stepctl_pkg.sv */
package stepctl_pkg;

  typedef logic [63:0]        word_t;    // One SPI word
  typedef logic [7:0]         header_t;  // Command byte
  typedef logic signed [63:0] accum_t;   // Phase, increment, position
  typedef logic [7:0]         clk_div_t; // Tick divisor

  // One queued move, 193 bits
  typedef struct packed {
    logic   dir;
    word_t  duration;  // Ticks
    accum_t increment;
    accum_t accel;     // Added to increment each tick
  } move_t;

  typedef struct packed {
    logic     enable;
    clk_div_t clk_div;
  } motor_cfg_t;

  // Position within a multi-word message
  typedef enum logic [1:0] {
    MSG_HEADER,
    MSG_DURATION,
    MSG_INCREMENT,
    MSG_ACCEL
  } msg_state_t;

  typedef enum logic {
    DDA_IDLE,
    DDA_RUN
  } dda_state_t;

endpackage

/* src/stepctl_params.svh */
`ifndef STEPCTL_PARAMS_SVH
`define STEPCTL_PARAMS_SVH

// Command header codes, top byte of a header word
`define CMD_COORDINATED_STEP 8'h01
`define CMD_MOTOR_ENABLE     8'h0a
`define CMD_CLK_DIVISOR      8'h0e
`define CMD_API_VERSION      8'hfe

// Reported by the API version command
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd1
`define VERSION_PATCH 8'd0

`define MOVE_QUEUE_DEPTH 4 // Power of two
`define MOVE_QUEUE_BITS  2 // log2 of depth

// One step per 2^32 of accumulated phase, increments are 32.32
`define STEP_THRESHOLD 64'sh0000_0001_0000_0000

`define CLK_DIV_RESET 8'd40 // Tick every 41 cycles out of reset

`endif
